/* sata_dma_reg_pkg.sv */
package sata_dma_reg_pkg;

    typedef logic [3:0]  reg_addr_t;  // register index
    typedef logic [31:0] reg_word_t;  // register data

    // register map; CTRL and STATUS share one index (write ctrl, read status)
    localparam reg_addr_t REG_ADDR   = 4'h0;
    localparam reg_addr_t REG_LBA    = 4'h1;
    localparam reg_addr_t REG_COUNT  = 4'h2;
    localparam reg_addr_t REG_CTRL   = 4'h3;
    localparam reg_addr_t REG_STATUS = 4'h3;

    localparam int CTRL_START_BIT = 0;  // launch transfer
    localparam int CTRL_DIR_BIT   = 1;  // 0 mem->disk, 1 disk->mem
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;  // sticky until next start

    localparam int SECTOR_ALIGN_BITS = 7;  // addr bits forced to zero

    typedef enum logic {
        DIR_TO_DISK   = 1'b0,  // memory -> disk
        DIR_FROM_DISK = 1'b1   // disk -> memory
    } dma_dir_e;

    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        reg_word_t data;
    } reg_req_t;

    typedef struct packed {
        reg_word_t mem_addr;  // byte address, sector aligned
        reg_word_t lba;
        reg_word_t count;     // sectors
        dma_dir_e  dir;
    } dma_job_t;

endpackage

/* sata_dma_data_pkg.sv */
package sata_dma_data_pkg;

    localparam int MEM_W  = 64;  // memory data port
    localparam int DISK_W = 32;  // disk data port
    localparam int ADDR_W = 32;  // byte address

    typedef logic [MEM_W-1:0]  mem_word_t;
    typedef logic [DISK_W-1:0] disk_word_t;
    typedef logic [ADDR_W-1:0] mem_addr_t;

    // one burst of one sector
    typedef struct packed {
        logic      write;  // set for disk -> memory
        mem_addr_t addr;
    } mem_cmd_t;

    typedef struct packed {
        logic        dir;    // dma_dir_e encoding
        logic [31:0] lba;
        logic [31:0] count;  // sectors
    } disk_cmd_t;

endpackage

/* sata_dma_regs.sv */
`timescale 1ns/1ps

module sata_dma_regs (
    input  logic                        aclk,
    input  logic                        rst,
    input  logic                        reg_req_valid,
    input  sata_dma_reg_pkg::reg_req_t  reg_req,
    output logic                        reg_req_ready,
    output logic                        reg_rsp_valid,
    output sata_dma_reg_pkg::reg_word_t reg_rsp_data,
    input  logic                        reg_rsp_ready,
    input  logic                        busy,
    input  logic                        done_pulse,
    output sata_dma_reg_pkg::dma_job_t  job,
    output logic                        start
);
    import sata_dma_reg_pkg::*;

    localparam reg_word_t ADDR_MASK = ~reg_word_t'((1 << SECTOR_ALIGN_BITS) - 1);

    reg_word_t addr_q;
    reg_word_t lba_q;
    reg_word_t count_q;
    dma_dir_e  dir_q;
    logic      done_q;
    logic      start_q;
    logic      req_fire;
    logic      engine_busy;
    logic      ctrl_wr;
    logic      launch;
    reg_word_t status_word;
    reg_word_t rd_word;

    assign reg_req_ready = !reg_rsp_valid;        // one pending response max
    assign req_fire      = reg_req_valid && reg_req_ready;
    assign engine_busy   = busy || start_q;       // start in flight counts as busy
    assign ctrl_wr       = req_fire && reg_req.write && (reg_req.addr == REG_CTRL);
    assign launch        = ctrl_wr && reg_req.data[CTRL_START_BIT] && !engine_busy;

    always_comb begin
        status_word                = '0;
        status_word[STAT_BUSY_BIT] = engine_busy;
        status_word[STAT_DONE_BIT] = done_q || done_pulse;  // visible in the pulse cycle
    end

    always_comb begin
        case (reg_req.addr)
            REG_ADDR:   rd_word = addr_q;
            REG_LBA:    rd_word = lba_q;
            REG_COUNT:  rd_word = count_q;
            REG_STATUS: rd_word = status_word;
            default:    rd_word = '0;  // undecoded
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            addr_q  <= '0;
            lba_q   <= '0;
            count_q <= '0;
            dir_q   <= DIR_TO_DISK;
            done_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= launch;  // one cycle pulse
            if (req_fire && reg_req.write) begin
                case (reg_req.addr)
                    REG_ADDR:  addr_q  <= reg_req.data & ADDR_MASK;  // sector aligned
                    REG_LBA:   lba_q   <= reg_req.data;
                    REG_COUNT: count_q <= reg_req.data;
                    default:   ;
                endcase
            end
            if (ctrl_wr && !engine_busy) begin
                dir_q <= dma_dir_e'(reg_req.data[CTRL_DIR_BIT]);  // busy -> ignored
            end
            if (launch) begin
                done_q <= 1'b0;  // new job clears done
            end else if (done_pulse) begin
                done_q <= 1'b1;
            end
        end
    end

    // read response, held until taken
    always_ff @(posedge aclk) begin
        if (rst) begin
            reg_rsp_valid <= 1'b0;
        end else if (req_fire && !reg_req.write) begin
            reg_rsp_valid <= 1'b1;
        end else if (reg_rsp_ready) begin
            reg_rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_fire && !reg_req.write) begin
            reg_rsp_data <= rd_word;  // captured with the read
        end
    end

    assign start = start_q;
    assign job   = '{mem_addr: addr_q, lba: lba_q, count: count_q, dir: dir_q};

endmodule

/* sata_dma_ctrl.sv */
`timescale 1ns/1ps

module sata_dma_ctrl #(
    parameter int SECTOR_WORDS = 64
) (
    input  logic                          aclk,
    input  logic                          rst,
    input  sata_dma_reg_pkg::dma_job_t    job,
    input  logic                          start,
    output logic                          busy,
    output logic                          done_pulse,
    output logic                          disk_cmd_valid,
    output sata_dma_data_pkg::disk_cmd_t  disk_cmd,
    input  logic                          disk_cmd_ready,
    output logic                          mem_cmd_valid,
    output sata_dma_data_pkg::mem_cmd_t   mem_cmd,
    input  logic                          mem_cmd_ready,
    output logic                          xfer_en,
    output sata_dma_reg_pkg::dma_dir_e    dir,
    input  logic                          sector_end
);
    import sata_dma_reg_pkg::*;
    import sata_dma_data_pkg::*;

    localparam mem_addr_t SECTOR_BYTES = mem_addr_t'(SECTOR_WORDS * 8);  // address step

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DISK_CMD,     // single command to disk side
        ST_MEM_CMD,      // one burst per sector
        ST_SECTOR_WAIT,  // data moving, wait for sector_end
        ST_FINISH        // done pulse
    } state_e;

    state_e    state_q;
    dma_dir_e  dir_q;
    reg_word_t left_q;   // sectors not yet commanded
    reg_word_t lba_q;
    reg_word_t count_q;
    mem_addr_t addr_q;   // address of next burst

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            dir_q   <= DIR_TO_DISK;
            left_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        dir_q   <= job.dir;
                        left_q  <= job.count;
                        state_q <= (job.count == '0) ? ST_FINISH : ST_DISK_CMD;  // zero count
                    end
                end
                ST_DISK_CMD: begin
                    if (disk_cmd_ready) begin
                        state_q <= ST_MEM_CMD;
                    end
                end
                ST_MEM_CMD: begin
                    if (mem_cmd_ready) begin
                        left_q  <= left_q - 1'b1;
                        state_q <= ST_SECTOR_WAIT;
                    end
                end
                ST_SECTOR_WAIT: begin
                    if (sector_end) begin
                        state_q <= (left_q == '0) ? ST_FINISH : ST_MEM_CMD;
                    end
                end
                ST_FINISH: state_q <= ST_IDLE;
                default:   state_q <= ST_IDLE;
            endcase
        end
    end

    // job payload, latched at start
    always_ff @(posedge aclk) begin
        if (state_q == ST_IDLE && start) begin
            lba_q   <= job.lba;
            count_q <= job.count;
            addr_q  <= job.mem_addr;
        end else if (state_q == ST_MEM_CMD && mem_cmd_ready) begin
            addr_q <= addr_q + SECTOR_BYTES;  // next sector
        end
    end

    assign busy       = (state_q == ST_DISK_CMD) || (state_q == ST_MEM_CMD) ||
                        (state_q == ST_SECTOR_WAIT);  // low in finish as done rises
    assign done_pulse = (state_q == ST_FINISH);

    assign disk_cmd_valid = (state_q == ST_DISK_CMD);
    assign disk_cmd       = '{dir: dir_q, lba: lba_q, count: count_q};

    assign mem_cmd_valid = (state_q == ST_MEM_CMD);
    assign mem_cmd       = '{write: (dir_q == DIR_FROM_DISK), addr: addr_q};

    assign xfer_en = (state_q == ST_SECTOR_WAIT);  // data only after its burst cmd
    assign dir     = dir_q;

endmodule

/* sata_dma_pack.sv */
`timescale 1ns/1ps

module sata_dma_pack #(
    parameter int SECTOR_WORDS = 64
) (
    input  logic                          aclk,
    input  logic                          rst,
    input  logic                          xfer_en,
    input  sata_dma_reg_pkg::dma_dir_e    dir,
    output logic                          sector_end,
    input  logic                          mem_rd_valid,
    input  sata_dma_data_pkg::mem_word_t  mem_rd_data,
    output logic                          mem_rd_ready,
    output logic                          mem_wr_valid,
    output sata_dma_data_pkg::mem_word_t  mem_wr_data,
    input  logic                          mem_wr_ready,
    output logic                          disk_wr_valid,
    output sata_dma_data_pkg::disk_word_t disk_wr_data,
    input  logic                          disk_wr_ready,
    input  logic                          disk_rd_valid,
    input  sata_dma_data_pkg::disk_word_t disk_rd_data,
    output logic                          disk_rd_ready
);
    import sata_dma_reg_pkg::*;
    import sata_dma_data_pkg::*;

    localparam int CNT_W = $clog2(SECTOR_WORDS);  // wraps once per sector

    mem_word_t        buf_q;     // the one word buffer
    logic             full_q;    // buffer holds a complete word
    logic             half_q;    // 0 low half, 1 high half
    logic [CNT_W-1:0] cnt_q;     // words gone out in this sector
    logic             to_disk;
    logic             mem_rd_fire;
    logic             mem_wr_fire;
    logic             disk_wr_fire;
    logic             disk_rd_fire;
    logic             word_out;

    assign to_disk = (dir == DIR_TO_DISK);

    // inactive side held off, input blocked while buffer full
    assign mem_rd_ready  = xfer_en && to_disk && !full_q;
    assign disk_rd_ready = xfer_en && !to_disk && !full_q;
    assign disk_wr_valid = full_q && to_disk;
    assign mem_wr_valid  = full_q && !to_disk;

    assign disk_wr_data = half_q ? buf_q[MEM_W-1:DISK_W] : buf_q[DISK_W-1:0];  // low first
    assign mem_wr_data  = buf_q;

    assign mem_rd_fire  = mem_rd_valid && mem_rd_ready;
    assign mem_wr_fire  = mem_wr_valid && mem_wr_ready;
    assign disk_wr_fire = disk_wr_valid && disk_wr_ready;
    assign disk_rd_fire = disk_rd_valid && disk_rd_ready;

    assign word_out   = (disk_wr_fire && half_q) || mem_wr_fire;  // a 64-bit word leaves
    assign sector_end = word_out && (cnt_q == CNT_W'(SECTOR_WORDS - 1));

    always_ff @(posedge aclk) begin
        if (rst) begin
            full_q <= 1'b0;
            half_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            if (to_disk) begin
                if (mem_rd_fire) begin
                    full_q <= 1'b1;
                    half_q <= 1'b0;
                end else if (disk_wr_fire) begin
                    full_q <= !half_q;  // empty after high half
                    half_q <= !half_q;
                end
            end else begin
                if (disk_rd_fire) begin
                    full_q <= half_q;   // full after second beat
                    half_q <= !half_q;
                end else if (mem_wr_fire) begin
                    full_q <= 1'b0;
                end
            end
            if (word_out) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // buffer payload
    always_ff @(posedge aclk) begin
        if (mem_rd_fire) begin
            buf_q <= mem_rd_data;
        end else if (disk_rd_fire) begin
            if (half_q) begin
                buf_q[MEM_W-1:DISK_W] <= disk_rd_data;  // second beat high
            end else begin
                buf_q[DISK_W-1:0] <= disk_rd_data;
            end
        end
    end

endmodule

/* sata_dma_top.sv */
`timescale 1ns/1ps

module sata_dma_top #(
    parameter int SECTOR_WORDS = 64
) (
    input  logic                          aclk,
    input  logic                          rst,
    // register port
    input  logic                          reg_req_valid,
    input  sata_dma_reg_pkg::reg_req_t    reg_req,
    output logic                          reg_req_ready,
    output logic                          reg_rsp_valid,
    output sata_dma_reg_pkg::reg_word_t   reg_rsp_data,
    input  logic                          reg_rsp_ready,
    // commands
    output logic                          disk_cmd_valid,
    output sata_dma_data_pkg::disk_cmd_t  disk_cmd,
    input  logic                          disk_cmd_ready,
    output logic                          mem_cmd_valid,
    output sata_dma_data_pkg::mem_cmd_t   mem_cmd,
    input  logic                          mem_cmd_ready,
    // memory data
    input  logic                          mem_rd_valid,
    input  sata_dma_data_pkg::mem_word_t  mem_rd_data,
    output logic                          mem_rd_ready,
    output logic                          mem_wr_valid,
    output sata_dma_data_pkg::mem_word_t  mem_wr_data,
    input  logic                          mem_wr_ready,
    // disk data
    output logic                          disk_wr_valid,
    output sata_dma_data_pkg::disk_word_t disk_wr_data,
    input  logic                          disk_wr_ready,
    input  logic                          disk_rd_valid,
    input  sata_dma_data_pkg::disk_word_t disk_rd_data,
    output logic                          disk_rd_ready
);
    import sata_dma_reg_pkg::*;

    dma_job_t job;         // regs -> ctrl
    logic     start;
    logic     busy;
    logic     done_pulse;
    logic     xfer_en;     // ctrl -> pack
    dma_dir_e dir;
    logic     sector_end;  // pack -> ctrl

    sata_dma_regs regs0 (
        .aclk          (aclk),
        .rst           (rst),
        .reg_req_valid (reg_req_valid),
        .reg_req       (reg_req),
        .reg_req_ready (reg_req_ready),
        .reg_rsp_valid (reg_rsp_valid),
        .reg_rsp_data  (reg_rsp_data),
        .reg_rsp_ready (reg_rsp_ready),
        .busy          (busy),
        .done_pulse    (done_pulse),
        .job           (job),
        .start         (start)
    );

    sata_dma_ctrl #(
        .SECTOR_WORDS (SECTOR_WORDS)
    ) ctrl0 (
        .aclk           (aclk),
        .rst            (rst),
        .job            (job),
        .start          (start),
        .busy           (busy),
        .done_pulse     (done_pulse),
        .disk_cmd_valid (disk_cmd_valid),
        .disk_cmd       (disk_cmd),
        .disk_cmd_ready (disk_cmd_ready),
        .mem_cmd_valid  (mem_cmd_valid),
        .mem_cmd        (mem_cmd),
        .mem_cmd_ready  (mem_cmd_ready),
        .xfer_en        (xfer_en),
        .dir            (dir),
        .sector_end     (sector_end)
    );

    sata_dma_pack #(
        .SECTOR_WORDS (SECTOR_WORDS)
    ) pack0 (
        .aclk          (aclk),
        .rst           (rst),
        .xfer_en       (xfer_en),
        .dir           (dir),
        .sector_end    (sector_end),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd_data   (mem_rd_data),
        .mem_rd_ready  (mem_rd_ready),
        .mem_wr_valid  (mem_wr_valid),
        .mem_wr_data   (mem_wr_data),
        .mem_wr_ready  (mem_wr_ready),
        .disk_wr_valid (disk_wr_valid),
        .disk_wr_data  (disk_wr_data),
        .disk_wr_ready (disk_wr_ready),
        .disk_rd_valid (disk_rd_valid),
        .disk_rd_data  (disk_rd_data),
        .disk_rd_ready (disk_rd_ready)
    );

endmodule

/* tb_sata_dma.sv */
`timescale 1ns/1ps

module tb_sata_dma;
    import sata_dma_reg_pkg::*;
    import sata_dma_data_pkg::*;

    localparam int SECTOR_WORDS = 8;    // short sectors keep the run short
    localparam int SAMPLE_DLY   = 40;   // strobe 10 ns before the rising edge
    localparam int N_XFER       = 3;    // jobs per direction
    localparam int MAX_SECTORS  = 2 * N_XFER * 4 + 2;
    localparam int TIMEOUT_CYCLES = 16 * MAX_SECTORS * SECTOR_WORDS + 2000;
    localparam logic [31:0] SEED      = 32'hd04dd82d;
    localparam logic [31:0] ADDR_MASK = ~((32'h1 << SECTOR_ALIGN_BITS) - 32'h1);

    logic       aclk = 1'b0;
    logic       rst;
    logic       reg_req_valid;
    reg_req_t   reg_req;
    logic       reg_req_ready;
    logic       reg_rsp_valid;
    reg_word_t  reg_rsp_data;
    logic       reg_rsp_ready;
    logic       disk_cmd_valid;
    disk_cmd_t  disk_cmd;
    logic       disk_cmd_ready;
    logic       mem_cmd_valid;
    mem_cmd_t   mem_cmd;
    logic       mem_cmd_ready;
    logic       mem_rd_valid;
    mem_word_t  mem_rd_data;
    logic       mem_rd_ready;
    logic       mem_wr_valid;
    mem_word_t  mem_wr_data;
    logic       mem_wr_ready;
    logic       disk_wr_valid;
    disk_word_t disk_wr_data;
    logic       disk_wr_ready;
    logic       disk_rd_valid;
    disk_word_t disk_rd_data;
    logic       disk_rd_ready;

    logic [31:0] rng_main;           // register values and data
    logic [31:0] rng_stall;          // stream stalls
    mem_word_t   mem_arr [0:1023];   // memory model, indexed by addr[12:3]
    mem_word_t   rd_q[$];            // words owed on mem_rd
    disk_word_t  disk_src[$];        // disk model read beats
    disk_word_t  exp_disk[$];        // reference: beats expected on disk_wr
    mem_word_t   exp_words[$];       // reference: words expected on mem_wr
    mem_cmd_t    exp_mem_cmd[$];
    disk_cmd_t   exp_disk_cmd;
    int          exp_disk_cmds = 0;
    int          disk_cmd_cnt  = 0;
    mem_addr_t   wr_addr;
    int          wr_left       = 0;  // write words announced by commands
    logic        mem_rd_taken  = 1'b0;
    logic        disk_rd_taken = 1'b0;
    int          err_cnt       = 0;
    int          test_err0     = 0;
    int          tests_run     = 0;
    int          tests_failed  = 0;
    int          cycle_cnt;

    sata_dma_top #(
        .SECTOR_WORDS (SECTOR_WORDS)
    ) dut0 (.*);

    always #50 aclk = ~aclk;  // 100 ns period

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // galois taps 32 22 2 1
    endfunction

    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v  = {v[62:0], st[0]};  // one step per bit
        end
    endtask

    task automatic flag_error(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (err_cnt == test_err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_cnt - test_err0);
        end
        test_err0 = err_cnt;
    endtask

    task automatic check_quiet();
        assert (!disk_cmd_valid && !mem_cmd_valid && !mem_wr_valid && !disk_wr_valid &&
                !reg_rsp_valid && !mem_rd_ready && !disk_rd_ready)
        else flag_error("stream valid or ready high in reset");
    endtask

    // request phase, returns at the strobe where the beat is taken
    task automatic send_req(input logic wr, input reg_addr_t a, input reg_word_t d);
        @(negedge aclk);
        reg_req_valid = 1'b1;
        reg_req       = '{write: wr, addr: a, data: d};
        #(SAMPLE_DLY);
        while (!reg_req_ready) begin
            @(negedge aclk);
            #(SAMPLE_DLY);
        end
    endtask

    task automatic reg_write(input reg_addr_t a, input reg_word_t d);
        send_req(1'b1, a, d);
        @(negedge aclk);
        reg_req_valid = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t a, output reg_word_t d);
        logic [63:0] r;
        send_req(1'b0, a, '0);
        do begin
            @(negedge aclk);
            reg_req_valid = 1'b0;
            draw_bits(rng_main, 2, r);
            reg_rsp_ready = |r[1:0];  // random response stall
            #(SAMPLE_DLY);
        end while (!(reg_rsp_valid && reg_rsp_ready));
        d = reg_rsp_data;
    endtask

    // reference model: commands, addresses and data order from the job
    task automatic prepare_job(input dma_dir_e d, input int cnt);
        logic [63:0] r;
        logic [31:0] addr_v;
        logic [31:0] lba_v;
        mem_addr_t   base;
        mem_cmd_t    mc;
        disk_word_t  lo;
        disk_word_t  hi;
        draw_bits(rng_main, 32, r);
        addr_v = r[31:0];
        draw_bits(rng_main, 32, r);
        lba_v = r[31:0];
        base  = addr_v & ADDR_MASK;
        for (int i = 0; i < cnt * SECTOR_WORDS; i++) begin
            draw_bits(rng_main, 32, r);
            lo = r[31:0];
            draw_bits(rng_main, 32, r);
            hi = r[31:0];
            if (d == DIR_TO_DISK) begin
                mem_arr[(base + i * 8) >> 3 & 1023] = {hi, lo};
                exp_disk.push_back(lo);  // low half first
                exp_disk.push_back(hi);
            end else begin
                disk_src.push_back(lo);  // first beat is the low half
                disk_src.push_back(hi);
                exp_words.push_back({hi, lo});
            end
        end
        for (int k = 0; k < cnt; k++) begin
            mc = '{write: (d == DIR_FROM_DISK), addr: base + k * SECTOR_WORDS * 8};
            exp_mem_cmd.push_back(mc);
        end
        if (cnt != 0) begin
            exp_disk_cmd = '{dir: d, lba: lba_v, count: cnt};
            exp_disk_cmds++;
        end
        reg_write(REG_ADDR, addr_v);
        reg_write(REG_LBA, lba_v);
        reg_write(REG_COUNT, cnt);
    endtask

    task automatic launch_job(input dma_dir_e d);
        reg_word_t w;
        w                 = '0;
        w[CTRL_START_BIT] = 1'b1;
        w[CTRL_DIR_BIT]   = d;
        reg_write(REG_CTRL, w);
    endtask

    task automatic wait_done();
        reg_word_t s;
        do begin
            reg_read(REG_STATUS, s);
        end while (!s[STAT_DONE_BIT]);
        assert (!s[STAT_BUSY_BIT]) else flag_error("busy still set with done");
    endtask

    task automatic check_job_end();
        assert (disk_cmd_cnt == exp_disk_cmds)
        else flag_error($sformatf("%0d disk commands, expected %0d", disk_cmd_cnt, exp_disk_cmds));
        assert (exp_mem_cmd.size() == 0) else flag_error("memory commands missing");
        assert (exp_disk.size() == 0 && exp_words.size() == 0) else flag_error("data missing");
        assert (rd_q.size() == 0 && disk_src.size() == 0 && wr_left == 0)
        else flag_error("stream data left over");
    endtask

    task automatic run_job(input dma_dir_e d, input int cnt);
        prepare_job(d, cnt);
        launch_job(d);
        wait_done();
        check_job_end();
    endtask

    // memory and disk models, fed by the handshakes seen at the strobe
    task automatic observe_streams();
        mem_addr_t a;
        if (disk_cmd_valid && disk_cmd_ready) begin
            disk_cmd_cnt++;
            assert (disk_cmd == exp_disk_cmd)
            else flag_error($sformatf("disk cmd %h, expected %h", disk_cmd, exp_disk_cmd));
        end
        if (mem_cmd_valid && mem_cmd_ready) begin
            assert (exp_mem_cmd.size() != 0)
            else flag_error($sformatf("unexpected memory cmd %h", mem_cmd));
            if (exp_mem_cmd.size() != 0) begin
                assert (mem_cmd == exp_mem_cmd[0])
                else flag_error($sformatf("mem cmd %h, expected %h", mem_cmd, exp_mem_cmd[0]));
                void'(exp_mem_cmd.pop_front());
            end
            if (mem_cmd.write) begin
                wr_addr = mem_cmd.addr;
                wr_left += SECTOR_WORDS;
            end else begin
                for (int i = 0; i < SECTOR_WORDS; i++) begin
                    a = mem_cmd.addr + i * 8;
                    rd_q.push_back(mem_arr[a[12:3]]);  // one sector burst
                end
            end
        end
        if (mem_rd_taken) void'(rd_q.pop_front());
        if (disk_rd_taken) void'(disk_src.pop_front());
        if (disk_wr_valid && disk_wr_ready) begin
            assert (exp_disk.size() != 0) else flag_error("unexpected disk write beat");
            if (exp_disk.size() != 0) begin
                assert (disk_wr_data == exp_disk[0])
                else flag_error($sformatf("disk beat %h, expected %h", disk_wr_data, exp_disk[0]));
                void'(exp_disk.pop_front());
            end
        end
        if (mem_wr_valid && mem_wr_ready) begin
            assert (wr_left > 0 && exp_words.size() != 0)
            else flag_error("memory write data without a write command");
            if (exp_words.size() != 0) begin
                assert (mem_wr_data == exp_words[0])
                else flag_error($sformatf("mem word %h, expected %h", mem_wr_data, exp_words[0]));
                void'(exp_words.pop_front());
            end
            mem_arr[wr_addr[12:3]] = mem_wr_data;
            wr_addr += 8;
            if (wr_left > 0) wr_left--;
        end
    endtask

    always begin : stream_models
        logic [63:0] st;
        @(negedge aclk);
        draw_bits(rng_stall, 12, st);
        if (rst) begin
            disk_cmd_ready = 1'b0;
            mem_cmd_ready  = 1'b0;
            mem_wr_ready   = 1'b0;
            disk_wr_ready  = 1'b0;
            mem_rd_valid   = 1'b0;
            disk_rd_valid  = 1'b0;
        end else begin
            disk_cmd_ready = |st[1:0];  // ready 3 cycles of 4
            mem_cmd_ready  = |st[3:2];
            mem_wr_ready   = |st[5:4];
            disk_wr_ready  = |st[7:6];
            if (!mem_rd_valid || mem_rd_taken) begin  // else hold until taken
                mem_rd_valid = (rd_q.size() != 0) && |st[9:8];
                if (rd_q.size() != 0) mem_rd_data = rd_q[0];
            end
            if (!disk_rd_valid || disk_rd_taken) begin
                disk_rd_valid = (disk_src.size() != 0) && |st[11:10];
                if (disk_src.size() != 0) disk_rd_data = disk_src[0];
            end
        end
        #(SAMPLE_DLY);
        mem_rd_taken  = mem_rd_valid && mem_rd_ready;
        disk_rd_taken = disk_rd_valid && disk_rd_ready;
        if (!rst) observe_streams();
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin : main_seq
        reg_word_t   s;
        reg_word_t   va;
        reg_word_t   vl;
        reg_word_t   vc;
        logic [63:0] r;
        rst            = 1'b1;
        rng_main       = SEED;
        rng_stall      = ~SEED;  // separate stream for stalls
        reg_req_valid  = 1'b0;
        reg_req        = '0;
        reg_rsp_ready  = 1'b0;
        disk_cmd_ready = 1'b0;
        mem_cmd_ready  = 1'b0;
        mem_rd_valid   = 1'b0;
        mem_rd_data    = '0;
        mem_wr_ready   = 1'b0;
        disk_wr_ready  = 1'b0;
        disk_rd_valid  = 1'b0;
        disk_rd_data   = '0;

        for (int i = 0; i < 15; i++) begin  // 16 rising edges in reset
            @(negedge aclk);
            #(SAMPLE_DLY);
            check_quiet();
        end
        @(negedge aclk);
        rst = 1'b0;
        #(SAMPLE_DLY);
        check_quiet();
        assert (reg_req_ready) else flag_error("reg_req_ready low after reset");
        reg_read(REG_STATUS, s);
        assert (!s[STAT_BUSY_BIT] && !s[STAT_DONE_BIT])
        else flag_error($sformatf("status %h after reset", s));
        close_test("reset state");

        for (int i = 0; i < 4; i++) begin
            draw_bits(rng_main, 32, r);
            va = r[31:0];
            draw_bits(rng_main, 32, r);
            vl = r[31:0];
            draw_bits(rng_main, 32, r);
            vc = r[31:0];
            reg_write(REG_ADDR, va);
            reg_write(REG_LBA, vl);
            reg_write(REG_COUNT, vc);
            reg_read(REG_ADDR, s);
            assert (s == (va & ADDR_MASK)) else flag_error($sformatf("ADDR read %h", s));
            reg_read(REG_LBA, s);
            assert (s == vl) else flag_error($sformatf("LBA read %h, wrote %h", s, vl));
            reg_read(REG_COUNT, s);
            assert (s == vc) else flag_error($sformatf("COUNT read %h, wrote %h", s, vc));
        end
        close_test("register readback");

        for (int t = 0; t < N_XFER; t++) begin
            draw_bits(rng_main, 2, r);
            run_job(DIR_TO_DISK, 1 + r[1:0]);  // 1 to 4 sectors
        end
        close_test("memory to disk");

        for (int t = 0; t < N_XFER; t++) begin
            draw_bits(rng_main, 2, r);
            run_job(DIR_FROM_DISK, 1 + r[1:0]);
        end
        close_test("disk to memory");

        prepare_job(DIR_TO_DISK, 2);
        launch_job(DIR_TO_DISK);
        reg_read(REG_STATUS, s);
        assert (s[STAT_BUSY_BIT] && !s[STAT_DONE_BIT])
        else flag_error($sformatf("status %h while running", s));
        launch_job(DIR_FROM_DISK);  // lands while busy
        wait_done();
        check_job_end();
        reg_read(REG_STATUS, s);
        assert (s[STAT_DONE_BIT] && !s[STAT_BUSY_BIT])
        else flag_error($sformatf("status %h after completion", s));
        close_test("status handshake");

        run_job(DIR_FROM_DISK, 0);  // no commands expected
        close_test("zero count");

        $display("summary: %0d run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sata_dma.f */
sata_dma_reg_pkg.sv
sata_dma_data_pkg.sv
sata_dma_regs.sv
sata_dma_ctrl.sv
sata_dma_pack.sv
sata_dma_top.sv
tb_sata_dma.sv

/* Bender.yml */
package:
  name: sata_dma

sources:
  - sata_dma_reg_pkg.sv
  - sata_dma_data_pkg.sv
  - sata_dma_regs.sv
  - sata_dma_ctrl.sv
  - sata_dma_pack.sv
  - sata_dma_top.sv
  - target: test
    files:
      - tb_sata_dma.sv
